// ==== verilog/dual_issue_pkg.sv ====
`default_nettype none

package dual_issue_pkg;

    localparam int REG_NUM = 32;  // architectural registers, x0 included

    typedef logic [4:0]  reg_addr_t;  // register index
    typedef logic [31:0] data_t;      // register / operand value

    // alu operation codes
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5,  // signed compare, result 1 or 0
        ALU_SLL = 3'd6,  // shift amount from b[4:0]
        ALU_SRL = 3'd7
    } alu_op_e;

    // decoded instruction at the issue port
    typedef struct packed {
        logic      valid;    // single-cycle strobe
        alu_op_e   op;
        logic      use_imm;  // b comes from imm, not rs2
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        data_t     imm;      // sign-extended by decode
    } issue_slot_t;

    // slot with operands already resolved
    typedef struct packed {
        logic      valid;
        alu_op_e   op;
        reg_addr_t rd;
        data_t     a;
        data_t     b;
    } ex_slot_t;

    // result heading for the register file
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        data_t     data;
    } wb_slot_t;

endpackage

`default_nettype wire

// ==== verilog/gpr.sv ====
`timescale 1ns/1ps
`default_nettype none

// general register file, 4 read ports and 2 write ports
// read ports: 0/1 = slot1 rs1/rs2, 2/3 = slot2 rs1/rs2
module gpr
    import dual_issue_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst_n_i,

    // write side, from the writeback register
    input  logic                    we1_i,     // port 1 write enable
    input  reg_addr_t               waddr1_i,  // port 1 target
    input  data_t                   wdata1_i,  // port 1 data
    input  logic                    we2_i,     // port 2 write enable
    input  reg_addr_t               waddr2_i,
    input  data_t                   wdata2_i,

    // read side, from operand read
    input  reg_addr_t [3:0]         raddr_i,
    output data_t     [3:0]         rdata_o
);

    data_t regs [REG_NUM];  // x0 entry kept but never written

    logic wr1_ok;  // port 1 actually writes something
    logic wr2_ok;

    // writes into x0 are dropped
    assign wr1_ok = we1_i && (waddr1_i != '0);
    assign wr2_ok = we2_i && (waddr2_i != '0);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= '0;  // every register reads zero after reset
            end
        end else begin
            if (wr2_ok) begin
                regs[waddr2_i] <= wdata2_i;
            end
            // port 1 assigned last, so it wins on equal addresses
            if (wr1_ok) begin
                regs[waddr1_i] <= wdata1_i;
            end
        end
    end

    // combinational read with same-cycle write forwarding
    // priority: x0, port 1, port 2, stored value
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            if (raddr_i[p] == '0) begin
                rdata_o[p] = '0;  // hardwired zero
            end else if (wr1_ok && (waddr1_i == raddr_i[p])) begin
                rdata_o[p] = wdata1_i;
            end else if (wr2_ok && (waddr2_i == raddr_i[p])) begin
                rdata_o[p] = wdata2_i;
            end else begin
                rdata_o[p] = regs[raddr_i[p]];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/operand_read.sv ====
`timescale 1ns/1ps
`default_nettype none

// first stage: register read, execute bypass, immediate select
module operand_read
    import dual_issue_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst_n_i,

    input  issue_slot_t         issue1_i,
    input  issue_slot_t         issue2_i,

    // execute-stage results, not yet written back
    input  wb_slot_t            fwd1_i,
    input  wb_slot_t            fwd2_i,

    // register file ports
    output reg_addr_t [3:0]     raddr_o,
    input  data_t     [3:0]     rdata_i,

    output ex_slot_t            ex1_o,    // registered
    output ex_slot_t            ex2_o
);

    ex_slot_t ex1_d;  // next packets
    ex_slot_t ex2_d;

    // bypass from execute; slot 1 result checked first
    // x0 and the writeback forward are already handled in gpr
    function automatic data_t resolve(reg_addr_t addr, data_t gpr_val,
                                      wb_slot_t f1, wb_slot_t f2);
        data_t val;
        if (addr == '0) begin
            val = gpr_val;  // gpr returns zero here
        end else if (f1.valid && (f1.rd == addr)) begin
            val = f1.data;
        end else if (f2.valid && (f2.rd == addr)) begin
            val = f2.data;
        end else begin
            val = gpr_val;
        end
        return val;
    endfunction

    assign raddr_o[0] = issue1_i.rs1;
    assign raddr_o[1] = issue1_i.rs2;
    assign raddr_o[2] = issue2_i.rs1;
    assign raddr_o[3] = issue2_i.rs2;

    always_comb begin
        ex1_d.valid = issue1_i.valid;
        ex1_d.op    = issue1_i.op;
        ex1_d.rd    = issue1_i.rd;
        ex1_d.a     = resolve(issue1_i.rs1, rdata_i[0], fwd1_i, fwd2_i);
        ex1_d.b     = issue1_i.use_imm ? issue1_i.imm :
                      resolve(issue1_i.rs2, rdata_i[1], fwd1_i, fwd2_i);
        ex2_d.valid = issue2_i.valid;
        ex2_d.op    = issue2_i.op;
        ex2_d.rd    = issue2_i.rd;
        ex2_d.a     = resolve(issue2_i.rs1, rdata_i[2], fwd1_i, fwd2_i);
        ex2_d.b     = issue2_i.use_imm ? issue2_i.imm :
                      resolve(issue2_i.rs2, rdata_i[3], fwd1_i, fwd2_i);
    end

    // valid bits cleared on reset
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex1_o.valid <= 1'b0;
            ex2_o.valid <= 1'b0;
        end else begin
            ex1_o.valid <= ex1_d.valid;
            ex2_o.valid <= ex2_d.valid;
        end
    end

    // payload, free running
    always_ff @(posedge clk) begin
        {ex1_o.op, ex1_o.rd, ex1_o.a, ex1_o.b} <= {ex1_d.op, ex1_d.rd, ex1_d.a, ex1_d.b};
        {ex2_o.op, ex2_o.rd, ex2_o.a, ex2_o.b} <= {ex2_d.op, ex2_d.rd, ex2_d.a, ex2_d.b};
    end

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

// rv32 integer alu, purely combinational
module alu
    import dual_issue_pkg::*;
(
    input  alu_op_e op_i,
    input  data_t   a_i,
    input  data_t   b_i,
    output data_t   result_o
);

    logic [4:0] shamt;    // low five bits of b
    logic       lt_sign;  // signed a < b

    assign shamt   = b_i[4:0];
    assign lt_sign = $signed(a_i) < $signed(b_i);

    always_comb begin
        unique case (op_i)
            ALU_ADD: result_o = a_i + b_i;
            ALU_SUB: result_o = a_i - b_i;
            ALU_AND: result_o = a_i & b_i;
            ALU_OR:  result_o = a_i | b_i;
            ALU_XOR: result_o = a_i ^ b_i;
            ALU_SLT: result_o = {31'd0, lt_sign};  // 1 or 0
            ALU_SLL: result_o = a_i << shamt;
            ALU_SRL: result_o = a_i >> shamt;       // logical, zero fill
            default: result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

// second stage: two alus and the writeback register
module execute_stage
    import dual_issue_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n_i,

    input  ex_slot_t    ex1_i,
    input  ex_slot_t    ex2_i,

    output wb_slot_t    fwd1_o,  // combinational, feeds the bypass
    output wb_slot_t    fwd2_o,

    output wb_slot_t    wb1_o,   // registered, to gpr and top
    output wb_slot_t    wb2_o
);

    data_t res1;
    data_t res2;

    alu u_alu1 (
        .op_i     (ex1_i.op),
        .a_i      (ex1_i.a),
        .b_i      (ex1_i.b),
        .result_o (res1)
    );

    alu u_alu2 (
        .op_i     (ex2_i.op),
        .a_i      (ex2_i.a),
        .b_i      (ex2_i.b),
        .result_o (res2)
    );

    // results as seen by operand read this cycle
    assign fwd1_o = '{valid: ex1_i.valid, rd: ex1_i.rd, data: res1};
    assign fwd2_o = '{valid: ex2_i.valid, rd: ex2_i.rd, data: res2};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb1_o.valid <= 1'b0;  // no writes right after reset
            wb2_o.valid <= 1'b0;
        end else begin
            wb1_o.valid <= fwd1_o.valid;
            wb2_o.valid <= fwd2_o.valid;
        end
    end

    always_ff @(posedge clk) begin
        {wb1_o.rd, wb1_o.data} <= {fwd1_o.rd, fwd1_o.data};
        {wb2_o.rd, wb2_o.data} <= {fwd2_o.rd, fwd2_o.data};
    end

endmodule

`default_nettype wire

// ==== verilog/dual_issue_core.sv ====
`timescale 1ns/1ps
`default_nettype none

// dual-issue integer datapath: operand read, execute, writeback
module dual_issue_core
    import dual_issue_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n_i,

    input  issue_slot_t     issue1_i,  // slot 1, wins on equal rd
    input  issue_slot_t     issue2_i,

    output wb_slot_t        wb1_o,     // two cycles after the strobe
    output wb_slot_t        wb2_o
);

    reg_addr_t [3:0] raddr;  // gpr read addresses
    data_t     [3:0] rdata;  // gpr read data, wb-forwarded

    ex_slot_t ex1;
    ex_slot_t ex2;
    wb_slot_t fwd1;  // execute bypass
    wb_slot_t fwd2;

    operand_read u_operand_read (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .issue1_i (issue1_i),
        .issue2_i (issue2_i),
        .fwd1_i   (fwd1),
        .fwd2_i   (fwd2),
        .raddr_o  (raddr),
        .rdata_i  (rdata),
        .ex1_o    (ex1),
        .ex2_o    (ex2)
    );

    execute_stage u_execute_stage (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .ex1_i   (ex1),
        .ex2_i   (ex2),
        .fwd1_o  (fwd1),
        .fwd2_o  (fwd2),
        .wb1_o   (wb1_o),
        .wb2_o   (wb2_o)
    );

    // writeback packets go straight into the write ports
    gpr u_gpr (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .we1_i    (wb1_o.valid),
        .waddr1_i (wb1_o.rd),
        .wdata1_i (wb1_o.data),
        .we2_i    (wb2_o.valid),
        .waddr2_i (wb2_o.rd),
        .wdata2_i (wb2_o.data),
        .raddr_i  (raddr),
        .rdata_o  (rdata)
    );

endmodule

`default_nettype wire

// ==== testbench/dual_issue_core_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

// protocol checks on the datapath top, bound into dual_issue_core
module dual_issue_core_sva
    import dual_issue_pkg::*;
(
    input wire         clk,
    input wire         rst_n_i,
    input issue_slot_t issue1_i,
    input issue_slot_t issue2_i,
    input wb_slot_t    wb1_i,  // dut wb1_o
    input wb_slot_t    wb2_i   // dut wb2_o
);

    int unsigned violations = 0;  // failed assertion count

    // first cycle out of reset has nothing to write back
    wb_idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n_i) |-> (!wb1_i.valid && !wb2_i.valid))
    else begin
        $error("wb valid high in the first cycle after reset");
        violations = violations + 1;
    end

    // every result has a strobe two cycles back in its own slot
    wb1_has_strobe: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb1_i.valid |-> $past(issue1_i.valid, 2))
    else begin
        $error("slot 1 result without a strobe two cycles earlier");
        violations = violations + 1;
    end

    wb2_has_strobe: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb2_i.valid |-> $past(issue2_i.valid, 2))
    else begin
        $error("slot 2 result without a strobe two cycles earlier");
        violations = violations + 1;
    end

    // a strobe is never lost, latency fixed at two
    strobe1_gives_wb: assert property (@(posedge clk) disable iff (!rst_n_i)
        issue1_i.valid |-> ##2 wb1_i.valid)
    else begin
        $error("slot 1 strobe produced no result two cycles later");
        violations = violations + 1;
    end

    strobe2_gives_wb: assert property (@(posedge clk) disable iff (!rst_n_i)
        issue2_i.valid |-> ##2 wb2_i.valid)
    else begin
        $error("slot 2 strobe produced no result two cycles later");
        violations = violations + 1;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_dual_issue_core.sv ====
`timescale 1ns/1ps
`default_nettype none

// testbench for the dual-issue datapath
// reference register model plus a two-cycle delay line of expected results
module tb_dual_issue_core
    import dual_issue_pkg::*;
();

    logic        clk = 1'b0;
    logic        rst_n;
    issue_slot_t issue1;
    issue_slot_t issue2;
    wb_slot_t    wb1;
    wb_slot_t    wb2;

    data_t          model [REG_NUM];  // architectural state after every issued bundle
    wb_slot_t [1:0] exp_new = '0;     // bundle driven this cycle with slot 1 in [0]
    wb_slot_t [1:0] dl1 = '0;         // one edge old
    wb_slot_t [1:0] dl2 = '0;         // due on the outputs now
    string          test_name;
    integer         seed;

    dual_issue_core dut_i (
        .clk      (clk),
        .rst_n_i  (rst_n),
        .issue1_i (issue1),
        .issue2_i (issue2),
        .wb1_o    (wb1),
        .wb2_o    (wb2)
    );

    bind dual_issue_core dual_issue_core_sva u_sva (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .issue1_i (issue1_i),
        .issue2_i (issue2_i),
        .wb1_i    (wb1_o),
        .wb2_i    (wb2_o)
    );

    initial begin
        forever #2 clk = ~clk;  // 4 ns period
    end

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1, "stopped at the first failing check");
    endtask

    // result of one op straight from the rv32 definitions
    function automatic data_t expected_result(alu_op_e f, data_t a, data_t b);
        data_t r;
        case (f)
            ALU_ADD: r = a + b;
            ALU_SUB: r = a + ~b + 32'd1;  // two's complement
            ALU_AND: r = a & b;
            ALU_OR:  r = a | b;
            ALU_XOR: r = a ^ b;
            // differing signs decided by the sign of a alone
            ALU_SLT: r = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            ALU_SLL: r = a << b[4:0];
            ALU_SRL: r = a >> b[4:0];
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic issue_slot_t make_slot(alu_op_e f, logic use_imm, int rd,
                                              int rs1, int rs2, data_t imm);
        issue_slot_t s;
        s.valid   = 1'b1;
        s.op      = f;
        s.use_imm = use_imm;
        s.rd      = reg_addr_t'(rd);
        s.rs1     = reg_addr_t'(rs1);
        s.rs2     = reg_addr_t'(rs2);
        s.imm     = imm;
        return s;
    endfunction

    function automatic issue_slot_t random_slot();
        issue_slot_t s;
        logic [31:0] r;
        r         = $random(seed);
        s.valid   = (r[1:0] != 2'b00);  // three slots in four valid
        s.op      = alu_op_e'(r[4:2]);
        s.use_imm = r[5];
        s.rd      = r[10:6];
        s.rs1     = r[15:11];
        s.rs2     = r[20:16];
        s.imm     = $random(seed);
        return s;
    endfunction

    // drive one bundle at the falling edge and update the model
    task automatic issue_bundle(input issue_slot_t s1, input issue_slot_t s2);
        issue_slot_t s [2];
        data_t       a;
        data_t       b;
        s[0] = s1;
        s[1] = s2;
        @(negedge clk);
        issue1 = s1;
        issue2 = s2;
        for (int k = 0; k < 2; k++) begin
            a = model[s[k].rs1];  // model[0] is never written
            b = s[k].use_imm ? s[k].imm : model[s[k].rs2];
            exp_new[k].valid = s[k].valid;
            exp_new[k].rd    = s[k].rd;
            exp_new[k].data  = expected_result(s[k].op, a, b);
        end
        // slot 2 written before slot 1 so slot 1 wins on equal rd
        for (int k = 1; k >= 0; k--) begin
            if (exp_new[k].valid && exp_new[k].rd != '0) begin
                model[exp_new[k].rd] = exp_new[k].data;
            end
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) issue_bundle('0, '0);
    endtask

    task automatic apply_reset();
        rst_n   = 1'b0;
        issue1  = '0;
        issue2  = '0;
        exp_new = '0;
        for (int i = 0; i < REG_NUM; i++) begin
            model[i] = '0;
        end
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // stop issuing and wait for the pipe to empty
    task automatic drain();
        int waited;
        issue_bundle('0, '0);
        waited = 0;
        while (wb1.valid || wb2.valid || dl1[0].valid || dl1[1].valid ||
               dl2[0].valid || dl2[1].valid) begin
            if (waited == 10) begin
                stop_with_error("timeout: outputs never went idle after the last bundle");
            end else begin
                @(negedge clk);
                waited++;
            end
        end
    endtask

    task automatic check_slot(input int slot, input wb_slot_t got, input wb_slot_t want);
        // rd and data only matter when a result is due
        assert (got.valid === want.valid &&
                (!want.valid || (got.rd === want.rd && got.data === want.data)))
        else stop_with_error($sformatf(
            "Error: %s slot%0d expected valid=%b rd=%0d data=%h actual valid=%b rd=%0d data=%h",
            test_name, slot, want.valid, want.rd, want.data, got.valid, got.rd, got.data));
    endtask

    // two-stage delay line flushed by reset like the pipe
    always @(posedge clk) begin
        if (!rst_n) begin
            dl1 = '0;
            dl2 = '0;
        end else begin
            dl2 = dl1;
            dl1 = exp_new;
        end
    end

    // outputs settled since the rising edge
    always @(negedge clk) begin
        check_slot(1, wb1, dl2[0]);
        check_slot(2, wb2, dl2[1]);
        assert (dut_i.u_sva.violations == 0)
        else stop_with_error("a bound protocol assertion on the DUT top failed");
    end

    initial begin
        issue_slot_t s1;
        issue_slot_t s2;
        alu_op_e     op;
        seed      = 32'h86b;
        test_name = "reset";
        apply_reset();

        test_name = "alu_ops";
        issue_bundle(make_slot(ALU_ADD, 1, 1, 0, 0, 32'hffff_fff9),   // x1 = -7
                     make_slot(ALU_ADD, 1, 2, 0, 0, 32'h0000_0023));  // x2 = 35
        issue_bundle(make_slot(ALU_ADD, 1, 3, 0, 0, 32'h8000_0001),
                     make_slot(ALU_ADD, 1, 4, 0, 0, 32'h0000_0104));
        for (int k = 0; k < 8; k++) begin
            op = alu_op_e'(k);
            issue_bundle(make_slot(op, 0, 5 + k, 1, 2, '0),            // reg, reg
                         make_slot(op, 1, 13 + k, 3, 0, 32'hffff_ff85)); // reg, imm
            issue_bundle(make_slot(op, 1, 21 + k, 4, 0, 32'h0000_0011),
                         make_slot(op, 0, 29 + k % 3, 3, 1, '0));
        end

        test_name = "bypass";
        issue_bundle(make_slot(ALU_ADD, 1, 5, 0, 0, 32'd1), make_slot(ALU_ADD, 1, 6, 0, 0, 32'd2));
        for (int gap = 0; gap < 4; gap++) begin  // execute bypass, wb forward, stored
            for (int n = 0; n < 4; n++) begin
                issue_bundle(make_slot(ALU_ADD, 0, 5, 5, 6, '0),
                             make_slot(ALU_SUB, 0, 6, 6, 5, '0));
                idle_cycles(gap);
            end
        end

        test_name = "x0";
        issue_bundle(make_slot(ALU_ADD, 1, 0, 0, 0, 32'd123),  // data shown but not stored
                     make_slot(ALU_OR, 1, 0, 7, 0, 32'h55));
        issue_bundle(make_slot(ALU_ADD, 0, 8, 0, 0, '0), make_slot(ALU_OR, 1, 9, 0, 0, '0));
        idle_cycles(1);
        issue_bundle(make_slot(ALU_SUB, 0, 10, 0, 0, '0), make_slot(ALU_ADD, 0, 11, 0, 0, '0));

        test_name = "same_rd";
        issue_bundle(make_slot(ALU_ADD, 1, 7, 0, 0, 32'h111),
                     make_slot(ALU_ADD, 1, 7, 0, 0, 32'h222));
        issue_bundle(make_slot(ALU_OR, 1, 8, 7, 0, '0), make_slot(ALU_OR, 1, 9, 7, 0, '0));
        idle_cycles(2);
        issue_bundle(make_slot(ALU_OR, 1, 8, 7, 0, '0), make_slot(ALU_OR, 1, 9, 7, 0, '0));
        // slot 2 must still see the old x7
        issue_bundle(make_slot(ALU_ADD, 1, 7, 0, 0, 32'h444), make_slot(ALU_ADD, 0, 11, 7, 0, '0));

        test_name = "reset";
        drain();
        apply_reset();
        for (int k = 1; k < REG_NUM; k += 2) begin
            issue_bundle(make_slot(ALU_OR, 0, k, k, k, '0),
                         make_slot(ALU_OR, 0, k + 1, k + 1, k + 1, '0));
        end

        test_name = "random";
        for (int n = 0; n < 300; n++) begin
            s1 = random_slot();
            s2 = random_slot();
            issue_bundle(s1, s2);
        end
        drain();

        if (dut_i.u_sva.violations == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            stop_with_error("bound protocol assertions reported violations");
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
verilog/dual_issue_pkg.sv
verilog/gpr.sv
verilog/operand_read.sv
verilog/alu.sv
verilog/execute_stage.sv
verilog/dual_issue_core.sv
testbench/dual_issue_core_sva.sv
testbench/tb_dual_issue_core.sv

// ==== Bender.yml ====
package:
  name: dual_issue_core

sources:
  - files:
      - verilog/dual_issue_pkg.sv
      - verilog/gpr.sv
      - verilog/operand_read.sv
      - verilog/alu.sv
      - verilog/execute_stage.sv
      - verilog/dual_issue_core.sv
  - target: test
    files:
      - testbench/dual_issue_core_sva.sv
      - testbench/tb_dual_issue_core.sv
